/* hw/ptw_pkg.sv */
////////////////////
// Sv39 page table walker shared types
// Address widths, PTE layout, walk states, levels, result kinds and cause codes
////////////////////

package ptw_pkg;

    // Sv39 address geometry
    localparam int unsigned vlen    = 39;
    localparam int unsigned plen    = 56;
    localparam int unsigned ppn_w   = 44;
    localparam int unsigned pscid_w = 20;

    // 64-bit Sv39 PTE, MSB first
    typedef struct packed {
        logic [9:0]       reserved;
        logic [ppn_w-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // Miss handed over by the translation cache
    typedef struct packed {
        logic [vlen-1:0]    iova;
        logic [pscid_w-1:0] pscid;
        logic               is_store;
    } miss_req_t;

    // Walk levels, lvl1 maps 1G
    typedef enum logic [1:0] {
        lvl1,
        lvl2,
        lvl3
    } level_e;

    // Execute FSM states
    typedef enum logic [1:0] {
        idle,
        fetch,
        finish
    } walk_state_e;

    // How a walk ended
    typedef enum logic [1:0] {
        kind_update,
        kind_fault,
        kind_bus_err,
        kind_bare
    } kind_e;

    // Cause codes reported with error_o
    typedef enum logic [11:0] {
        load_page_fault    = 12'd13,
        store_page_fault   = 12'd15,
        pt_data_corruption = 12'd274
    } cause_e;

    // Decode verdict on the PTE currently on the bus
    typedef struct packed {
        logic leaf;
        logic fault;
        logic next_ok;
    } pte_verdict_t;

    // Translation cache update entry
    typedef struct packed {
        logic [26:0]        vpn;
        logic [pscid_w-1:0] pscid;
        pte_t               pte;
        logic               is_2m;
        logic               is_1g;
    } tlb_entry_t;

endpackage

/* hw/ptw_pte_decode.sv */
////////////////////
// Sv39 PTE decoder
// Classifies a fetched PTE and flags page-fault rules
// for the current level and access type
////////////////////

`timescale 1ns/1ps

module ptw_pte_decode (
    input  ptw_pkg::level_e       level_i,
    input  logic                  is_store_i,
    input  ptw_pkg::pte_t         pte_i,
    output ptw_pkg::pte_verdict_t verdict_o
);

    logic is_leaf;
    logic bad_encoding;
    logic bad_reserved;
    logic bad_pointer;
    logic misaligned;
    logic bad_leaf;
    logic any_fault;

    // R or X marks a leaf, anything else points to the next table
    assign is_leaf = pte_i.r | pte_i.x;

    // Invalid entry or the reserved W-without-R encoding
    assign bad_encoding = !pte_i.v || (pte_i.w && !pte_i.r);

    // Upper ten bits must be zero, no extension implemented here
    assign bad_reserved = |pte_i.reserved;

    always_comb begin
        // D, A and U are reserved on pointers
        bad_pointer = pte_i.d || pte_i.a || pte_i.u;
        // No table below lvl3, a pointer there ends the walk
        if (level_i == ptw_pkg::lvl3) begin
            bad_pointer = 1'b1;
        end
    end

    always_comb begin
        // Superpage PPN must be aligned to its size
        case (level_i)
            ptw_pkg::lvl1: misaligned = |pte_i.ppn[17:0];
            ptw_pkg::lvl2: misaligned = |pte_i.ppn[8:0];
            default:       misaligned = 1'b0;
        endcase
    end

    always_comb begin
        // Access flag must already be set by software
        bad_leaf = !pte_i.a;
        // Execute-only leaves cannot serve a read or write
        if (!pte_i.r) begin
            bad_leaf = 1'b1;
        end
        if (misaligned) begin
            bad_leaf = 1'b1;
        end
        // Stores need the dirty bit
        if (is_store_i && !pte_i.d) begin
            bad_leaf = 1'b1;
        end
    end

    // Pointer and leaf rules only apply to a well-formed entry
    assign any_fault = bad_encoding
                    || bad_reserved
                    || (!is_leaf && bad_pointer)
                    || (is_leaf && bad_leaf);

    assign verdict_o.leaf    = is_leaf;
    assign verdict_o.fault   = any_fault;
    // Clean pointer above lvl3, safe to follow
    assign verdict_o.next_ok = !is_leaf && !any_fault;

endmodule

/* hw/ptw_walk_exec.sv */
////////////////////
// Sv39 walk execute stage
// Walk FSM, level counter, PTE pointer generation
// and Wishbone classic read master
////////////////////

`timescale 1ns/1ps

module ptw_walk_exec (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        en_i,
    input  logic [ptw_pkg::ppn_w-1:0]   root_ppn_i,
    input  logic                        miss_valid_i,
    input  ptw_pkg::miss_req_t          miss_i,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic [ptw_pkg::plen-1:0]    wb_adr_o,
    input  ptw_pkg::pte_t               wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic                        wb_err_i,
    input  ptw_pkg::pte_verdict_t       verdict_i,
    output ptw_pkg::level_e             level_o,
    output logic                        is_store_o,
    output logic                        finish_o,
    output ptw_pkg::kind_e              kind_o,
    output ptw_pkg::level_e             final_level_o,
    output logic                        global_o,
    output ptw_pkg::miss_req_t          req_o,
    output logic                        busy_o
);

    ptw_pkg::walk_state_e            state_q, state_d;
    ptw_pkg::level_e                 level_q, level_d;
    logic                            cyc_q, cyc_d;
    logic                            global_q, global_d;
    ptw_pkg::miss_req_t              req_q;
    logic [ptw_pkg::plen-1:0]        pptr_q, pptr_d;
    logic                            accept;
    logic                            bus_done;
    logic                            walk_end;
    logic [8:0]                      vpn_next;

    // Only an idle walker takes a miss, busy misses are dropped
    assign accept   = (state_q == ptw_pkg::idle) && miss_valid_i;
    // Bus cycle closes on either ack or err
    assign bus_done = cyc_q && (wb_ack_i || wb_err_i);
    // Walk stops on err or on anything that is not a clean pointer
    assign walk_end = bus_done && (wb_err_i || !verdict_i.next_ok);

    // VPN field indexing the table one level down
    assign vpn_next = (level_q == ptw_pkg::lvl1) ? req_q.iova[29:21] : req_q.iova[20:12];

    always_comb begin
        // Bare result comes straight from the accept cycle
        if (state_q == ptw_pkg::idle) begin
            kind_o = ptw_pkg::kind_bare;
        end else if (wb_err_i) begin
            kind_o = ptw_pkg::kind_bus_err;
        end else if (verdict_i.leaf && !verdict_i.fault) begin
            kind_o = ptw_pkg::kind_update;
        end else begin
            kind_o = ptw_pkg::kind_fault;
        end
    end

    // Result stage samples on this edge, pulse shows one cycle later
    assign finish_o      = (accept && !en_i) || walk_end;
    assign final_level_o = level_q;
    assign global_o      = global_q;
    assign req_o         = req_q;

    assign level_o    = level_q;
    assign is_store_o = req_q.is_store;
    assign busy_o     = (state_q != ptw_pkg::idle);

    // Classic read, stb follows cyc and the address is held in pptr_q
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_adr_o = pptr_q;

    always_comb begin
        state_d  = state_q;
        level_d  = level_q;
        cyc_d    = cyc_q;
        global_d = global_q;
        pptr_d   = pptr_q;

        case (state_q)
            ptw_pkg::idle: begin
                if (accept) begin
                    if (en_i) begin
                        // First read at root table, indexed by VPN[2]
                        pptr_d   = {root_ppn_i, miss_i.iova[38:30], 3'b000};
                        level_d  = ptw_pkg::lvl1;
                        global_d = 1'b0;
                        cyc_d    = 1'b1;
                        state_d  = ptw_pkg::fetch;
                    end else begin
                        // Translation off, report bare and skip memory
                        state_d = ptw_pkg::finish;
                    end
                end
            end

            ptw_pkg::fetch: begin
                if (!cyc_q) begin
                    // Idle gap after the previous ack is over
                    cyc_d = 1'b1;
                end else if (bus_done) begin
                    cyc_d    = 1'b0;
                    global_d = global_q | (wb_ack_i & wb_dat_i.g);
                    if (walk_end) begin
                        state_d = ptw_pkg::finish;
                    end else begin
                        // Descend one level through the pointer PTE
                        pptr_d  = {wb_dat_i.ppn, vpn_next, 3'b000};
                        level_d = (level_q == ptw_pkg::lvl1) ? ptw_pkg::lvl2 : ptw_pkg::lvl3;
                    end
                end
            end

            // Result pulse is on the outputs this cycle
            ptw_pkg::finish: begin
                state_d = ptw_pkg::idle;
            end

            default: begin
                state_d = ptw_pkg::idle;
                cyc_d   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= ptw_pkg::idle;
            level_q  <= ptw_pkg::lvl1;
            cyc_q    <= 1'b0;
            global_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            level_q  <= level_d;
            cyc_q    <= cyc_d;
            global_q <= global_d;
        end
    end

    // Held miss and pointer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= miss_i;
        end
        pptr_q <= pptr_d;
    end

endmodule

/* hw/ptw_result.sv */
////////////////////
// Sv39 walk result stage
// Registers the cache update entry, the error cause
// or the bare flag and pulses it for one cycle
////////////////////

`timescale 1ns/1ps

module ptw_result (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  finish_i,
    input  ptw_pkg::kind_e        kind_i,
    input  ptw_pkg::level_e       final_level_i,
    input  logic                  global_i,
    input  ptw_pkg::miss_req_t    req_i,
    input  ptw_pkg::pte_t         pte_i,
    output logic                  update_o,
    output ptw_pkg::tlb_entry_t   update_entry_o,
    output logic                  error_o,
    output ptw_pkg::cause_e       cause_o,
    output logic                  bare_o
);

    ptw_pkg::tlb_entry_t entry_d, entry_q;
    ptw_pkg::cause_e     cause_d, cause_q;
    logic                update_q;
    logic                error_q;
    logic                bare_q;

    always_comb begin
        // Entry tag is VPN[2:0] of the IOVA plus the PSCID
        entry_d.vpn   = req_i.iova[38:12];
        entry_d.pscid = req_i.pscid;
        entry_d.pte   = pte_i;
        // Global from any pointer on the way down sticks to the leaf
        entry_d.pte.g = pte_i.g | global_i;
        entry_d.is_1g = (final_level_i == ptw_pkg::lvl1);
        entry_d.is_2m = (final_level_i == ptw_pkg::lvl2);
    end

    always_comb begin
        // Page faults follow the access type, bus errors do not
        if (kind_i == ptw_pkg::kind_bus_err) begin
            cause_d = ptw_pkg::pt_data_corruption;
        end else if (req_i.is_store) begin
            cause_d = ptw_pkg::store_page_fault;
        end else begin
            cause_d = ptw_pkg::load_page_fault;
        end
    end

    // One-cycle strobes, exactly one per finished walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            update_q <= 1'b0;
            error_q  <= 1'b0;
            bare_q   <= 1'b0;
        end else begin
            update_q <= finish_i && (kind_i == ptw_pkg::kind_update);
            error_q  <= finish_i && ((kind_i == ptw_pkg::kind_fault)
                                  || (kind_i == ptw_pkg::kind_bus_err));
            bare_q   <= finish_i && (kind_i == ptw_pkg::kind_bare);
        end
    end

    // Leaf PTE taken from the bus on the same ack edge
    always_ff @(posedge clk_i) begin
        if (finish_i) begin
            entry_q <= entry_d;
            cause_q <= cause_d;
        end
    end

    assign update_o       = update_q;
    assign update_entry_o = entry_q;
    assign error_o        = error_q;
    assign cause_o        = cause_q;
    assign bare_o         = bare_q;

endmodule

/* hw/ptw_top.sv */
////////////////////
// Sv39 page table walker top
// Joins PTE decode, walk execute and result stages
////////////////////

`timescale 1ns/1ps

module ptw_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        en_i,
    input  logic [ptw_pkg::ppn_w-1:0]   root_ppn_i,
    input  logic                        miss_valid_i,
    input  ptw_pkg::miss_req_t          miss_i,
    output logic                        busy_o,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic [ptw_pkg::plen-1:0]    wb_adr_o,
    input  ptw_pkg::pte_t               wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic                        wb_err_i,
    output logic                        update_o,
    output ptw_pkg::tlb_entry_t         update_entry_o,
    output logic                        error_o,
    output ptw_pkg::cause_e             cause_o,
    output logic                        bare_o
);

    ptw_pkg::pte_verdict_t verdict;
    ptw_pkg::level_e       level;
    logic                  is_store;
    logic                  finish;
    ptw_pkg::kind_e        kind;
    ptw_pkg::level_e       final_level;
    logic                  walk_global;
    ptw_pkg::miss_req_t    req;

    // Combinational check of the PTE on the bus
    ptw_pte_decode u_decode (
        .level_i    (level),
        .is_store_i (is_store),
        .pte_i      (wb_dat_i),
        .verdict_o  (verdict)
    );

    ptw_walk_exec u_exec (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .en_i          (en_i),
        .root_ppn_i    (root_ppn_i),
        .miss_valid_i  (miss_valid_i),
        .miss_i        (miss_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .wb_err_i      (wb_err_i),
        .verdict_i     (verdict),
        .level_o       (level),
        .is_store_o    (is_store),
        .finish_o      (finish),
        .kind_o        (kind),
        .final_level_o (final_level),
        .global_o      (walk_global),
        .req_o         (req),
        .busy_o        (busy_o)
    );

    // Leaf PTE comes straight off the bus
    ptw_result u_result (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .finish_i       (finish),
        .kind_i         (kind),
        .final_level_i  (final_level),
        .global_i       (walk_global),
        .req_i          (req),
        .pte_i          (wb_dat_i),
        .update_o       (update_o),
        .update_entry_o (update_entry_o),
        .error_o        (error_o),
        .cause_o        (cause_o),
        .bare_o         (bare_o)
    );

endmodule

/* tests/ptw_chk.sv */
////////////////////
// Sv39 walker protocol checker
// Wishbone read rules and result strobe rules, bound into the walker top
////////////////////

`timescale 1ns/1ps

module ptw_chk (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        busy_i,
    input logic        cyc_i,
    input logic        stb_i,
    input logic [55:0] adr_i,
    input logic        ack_i,
    input logic        err_i,
    input logic        update_i,
    input logic        error_i,
    input logic        bare_i
);

    // Sticky flag raised by any failed property
    logic chk_fail = 1'b0;

    // Classic single read, stb never differs from cyc
    stb_follows_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stb_i == cyc_i)
        else begin
            $error("wishbone stb differs from cyc");
            chk_fail = 1'b1;
        end

    // Address held until the slave answers
    adr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (cyc_i && !ack_i && !err_i) |=> $stable(adr_i))
        else begin
            $error("wishbone address moved before ack or err");
            chk_fail = 1'b1;
        end

    // At most one result strobe per cycle
    one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({update_i, error_i, bare_i}))
        else begin
            $error("more than one result strobe high");
            chk_fail = 1'b1;
        end

    // Walker comes out of reset idle
    idle_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!busy_i && !cyc_i))
        else begin
            $error("walker busy right after reset");
            chk_fail = 1'b1;
        end

endmodule

bind ptw_top ptw_chk u_chk (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .busy_i   (busy_o),
    .cyc_i    (wb_cyc_o),
    .stb_i    (wb_stb_o),
    .adr_i    (wb_adr_o),
    .ack_i    (wb_ack_i),
    .err_i    (wb_err_i),
    .update_i (update_o),
    .error_i  (error_o),
    .bare_i   (bare_o)
);

/* tests/tb_ptw.sv */
////////////////////
// Sv39 page table walker testbench
// Wishbone memory model with random ack delay, misses and
// expected results read from the test data file
////////////////////

`timescale 1ns/1ps

module tb_ptw;

    // Root table sits at physical 0x100000
    localparam logic [43:0] root_ppn = 44'h100;
    localparam int unsigned result_timeout = 300;

    // One miss with its expected result, kind 0 update, 1 error, 2 bare
    typedef struct packed {
        logic        en;
        logic [38:0] iova;
        logic [19:0] pscid;
        logic        is_store;
        logic [1:0]  kind;
        logic [63:0] pte;
        logic        is_2m;
        logic        is_1g;
        logic [11:0] cause;
    } test_rec_t;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 en_i;
    logic [43:0]          root_ppn_i;
    logic                 miss_valid_i;
    ptw_pkg::miss_req_t   miss_i;
    logic                 busy_o;
    logic                 wb_cyc_o;
    logic                 wb_stb_o;
    logic [55:0]          wb_adr_o;
    ptw_pkg::pte_t        wb_dat_i;
    logic                 wb_ack_i;
    logic                 wb_err_i;
    logic                 update_o;
    ptw_pkg::tlb_entry_t  update_entry_o;
    logic                 error_o;
    ptw_pkg::cause_e      cause_o;
    logic                 bare_o;

    // Memory image and addresses that answer with err
    logic [63:0] mem [logic [55:0]];
    bit          err_map [logic [55:0]];
    test_rec_t   tests[$];

    // Reference walk state shared with the slave model
    logic [38:0] cur_iova;
    logic [55:0] exp_adr;
    int          exp_lvl;
    logic        cyc_seen;
    int          err_cnt;

    ptw_top dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .en_i           (en_i),
        .root_ppn_i     (root_ppn_i),
        .miss_valid_i   (miss_valid_i),
        .miss_i         (miss_i),
        .busy_o         (busy_o),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i),
        .wb_err_i       (wb_err_i),
        .update_o       (update_o),
        .update_entry_o (update_entry_o),
        .error_o        (error_o),
        .cause_o        (cause_o),
        .bare_o         (bare_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic stop_run();
        err_cnt++;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // Protocol property failures in the bound checker end the run
    always @(posedge dut.u_chk.chk_fail) begin
        abort_run("bus or result protocol property failed in bound checker");
    end

    // Sv39 rule, next table PPN from the PTE joined with the next VPN field
    function automatic logic [55:0] next_pointer(input logic [63:0] pte, input int lvl,
                                                 input logic [38:0] iova);
        if (lvl == 1) begin
            return {pte[53:10], iova[29:21], 3'b000};
        end
        return {pte[53:10], iova[20:12], 3'b000};
    endfunction

    task automatic load_test_file();
        int          fd;
        int          n;
        string       line;
        logic [63:0] col [0:8];
        test_rec_t   t;
        fd = $fopen("tests/ptw_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/ptw_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2) begin
                continue;
            end
            if (line[0] == "M") begin
                n = $sscanf(line, "M %h %h", col[0], col[1]);
                mem[col[0][55:0]] = col[1];
            end else if (line[0] == "E") begin
                n = $sscanf(line, "E %h", col[0]);
                err_map[col[0][55:0]] = 1'b1;
            end else if (line[0] == "T") begin
                n = $sscanf(line, "T %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                            col[3], col[4], col[5], col[6], col[7], col[8]);
                if (n != 9) begin
                    abort_run("malformed miss record in test data file");
                end
                t.en       = col[0][0];
                t.iova     = col[1][38:0];
                t.pscid    = col[2][19:0];
                t.is_store = col[3][0];
                t.kind     = col[4][1:0];
                t.pte      = col[5];
                t.is_2m    = col[6][0];
                t.is_1g    = col[7][0];
                t.cause    = col[8][11:0];
                tests.push_back(t);
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            abort_run("test data file holds no miss records");
        end
    endtask

    // Wishbone slave, one random wait of 0 to 5 cycles per read
    initial begin : wb_slave
        int unsigned delay;
        int unsigned seed_ret;
        logic        serving;
        logic [63:0] rd_data;
        seed_ret = $urandom(32'h445c);
        wb_ack_i = 1'b0;
        wb_err_i = 1'b0;
        wb_dat_i = '0;
        serving  = 1'b0;
        delay    = 0;
        forever begin
            @(posedge clk_i);
            if (wb_ack_i || wb_err_i) begin
                wb_ack_i <= 1'b0;
                wb_err_i <= 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                cyc_seen = 1'b1;
                if (!serving) begin
                    serving = 1'b1;
                    delay   = $urandom % 6;
                    assert (wb_adr_o == exp_adr)
                    else report_mismatch($sformatf("bus address %h, expected %h",
                                                   wb_adr_o, exp_adr));
                end
                if (delay == 0) begin
                    serving = 1'b0;
                    if (err_map.exists(wb_adr_o)) begin
                        wb_dat_i <= '0;
                        wb_err_i <= 1'b1;
                    end else begin
                        rd_data  = mem.exists(wb_adr_o) ? mem[wb_adr_o] : 64'h0;
                        wb_dat_i <= rd_data;
                        wb_ack_i <= 1'b1;
                        exp_adr  = next_pointer(rd_data, exp_lvl, cur_iova);
                        exp_lvl++;
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic run_miss(input test_rec_t t);
        int unsigned         wait_cnt;
        ptw_pkg::tlb_entry_t exp_entry;
        // Reference pointer for the root table read
        cur_iova = t.iova;
        exp_adr  = {root_ppn, t.iova[38:30], 3'b000};
        exp_lvl  = 1;
        cyc_seen = 1'b0;
        en_i           <= t.en;
        miss_i.iova     <= t.iova;
        miss_i.pscid    <= t.pscid;
        miss_i.is_store <= t.is_store;
        miss_valid_i   <= 1'b1;
        @(posedge clk_i);
        assert (!busy_o) else report_mismatch("miss offered while walker busy");
        miss_valid_i <= 1'b0;
        wait_cnt = 0;
        while (!(update_o || error_o || bare_o) && wait_cnt < result_timeout) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (wait_cnt >= result_timeout) begin
            abort_run($sformatf("no result for miss at iova %h", t.iova));
        end
        assert (busy_o) else report_mismatch("busy low during result pulse");
        exp_entry.vpn   = t.iova[38:12];
        exp_entry.pscid = t.pscid;
        exp_entry.pte   = t.pte;
        exp_entry.is_2m = t.is_2m;
        exp_entry.is_1g = t.is_1g;
        case (t.kind)
            2'd0: begin
                assert (update_o && !error_o && !bare_o)
                else report_mismatch($sformatf("iova %h expected update", t.iova));
                assert (update_entry_o == exp_entry)
                else report_mismatch($sformatf("entry %h, expected %h",
                                               update_entry_o, exp_entry));
            end
            2'd1: begin
                assert (error_o && !update_o && !bare_o)
                else report_mismatch($sformatf("iova %h expected error", t.iova));
                assert (cause_o == t.cause)
                else report_mismatch($sformatf("cause %0d, expected %0d", cause_o, t.cause));
            end
            default: begin
                assert (bare_o && !update_o && !error_o)
                else report_mismatch($sformatf("iova %h expected bare", t.iova));
                assert (!cyc_seen) else report_mismatch("bus cycle during bare request");
            end
        endcase
    endtask

    initial begin : main_flow
        err_cnt      = 0;
        rst_ni       = 1'b0;
        en_i         = 1'b0;
        root_ppn_i   = root_ppn;
        miss_valid_i = 1'b0;
        miss_i       = '0;
        cur_iova     = '0;
        exp_adr      = '0;
        exp_lvl      = 1;
        cyc_seen     = 1'b0;
        load_test_file();
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);
        foreach (tests[i]) begin
            run_miss(tests[i]);
        end
        repeat (2) @(posedge clk_i);
        if (err_cnt == 0 && !dut.u_chk.chk_fail) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/ptw_pkg.sv
hw/ptw_pte_decode.sv
hw/ptw_walk_exec.sv
hw/ptw_result.sv
hw/ptw_top.sv
tests/ptw_chk.sv
tests/tb_ptw.sv

/* tests/ptw_tests.txt */
# M paddr pte_data | E paddr (read answers err)
# T en iova pscid is_store kind(0 upd,1 err,2 bare) exp_pte is_2m is_1g cause
M 00000000100000 0000000000040421
M 00000000100008 00000000100000C7
M 00000000100010 0000000000000000
M 00000000100018 00000000100004C7
M 00000000100020 0000000000040441
M 00000000101000 0000000000040801
M 00000000101008 0000000000080043
M 00000000102028 00000000000D14C7
M 00000000102030 00000000000D1847
M 00000000102038 0000000000040C01
E 00000000100028
T 1 0000005000 00012 0 0 00000000000D14E7 0 0 000
T 1 0040000000 00ABC 1 0 00000000100000C7 0 1 000
T 1 0000200000 00012 0 0 0000000000080063 1 0 000
T 1 0080000000 00001 0 1 0000000000000000 0 0 00D
T 1 00C0000000 00002 1 1 0000000000000000 0 0 00F
T 1 0000006000 00003 1 1 0000000000000000 0 0 00F
T 1 0100000000 00004 0 1 0000000000000000 0 0 00D
T 1 0000007000 00005 0 1 0000000000000000 0 0 00D
T 1 0140000000 00006 1 1 0000000000000000 0 0 112
T 0 0000005000 00007 0 2 0000000000000000 0 0 000
